//--- mul_cfg.svh
`ifndef MUL_CFG_SVH
`define MUL_CFG_SVH

// **************************************************
// multiply unit sizing
// **************************************************

// operand and result width, rv64
`define MUL_XLEN 64

// radix-4 steps for a full op
// operands extended by two bits to 66, two bits per step
`define MUL_STEPS 33

// radix-4 steps for mulw
// 32-bit operands extended to 34 bits
`define MUL_STEPS_W 17

`endif

//--- mul_pkg.sv
`default_nettype none

`include "mul_cfg.svh"

package mul_pkg;

	// **************************************************
	// operation codes
	// **************************************************

	// the five rv64m multiply flavours
	typedef enum logic [2:0] {
		OP_MUL    = 3'd0,
		OP_MULH   = 3'd1,
		OP_MULHSU = 3'd2,
		OP_MULHU  = 3'd3,
		OP_MULW   = 3'd4
	} mul_op_e;

	// **************************************************
	// block to block bundles
	// **************************************************

	// request as seen by the execute stage
	typedef struct packed {
		mul_op_e              op;
		logic [`MUL_XLEN-1:0] src_a;
		logic [`MUL_XLEN-1:0] src_b;
	} mul_req_t;

	// operands entering the booth datapath
	typedef struct packed {
		logic                 signed_a;
		logic                 signed_b;
		logic                 word;
		logic [`MUL_XLEN-1:0] multiplicand;
		logic [`MUL_XLEN-1:0] multiplier;
	} mul_start_t;

	// full product, truncated to twice xlen
	typedef struct packed {
		logic [`MUL_XLEN-1:0] hi;
		logic [`MUL_XLEN-1:0] lo;
	} mul_prod_t;

	// writeback control, held for the whole op
	typedef struct packed {
		logic take_hi;
		logic word;
	} mul_sel_t;

endpackage

`default_nettype wire

//--- booth_encoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_cfg.svh"

module booth_encoder (
	input  wire  [2:0]             digit,
	input  wire  [`MUL_XLEN+1:0]   multiplicand,
	output logic [`MUL_XLEN+3:0]   part
);

	// extended operand width, and partial product width with two guard bits
	localparam int EXT_W  = `MUL_XLEN + 2;
	localparam int PART_W = EXT_W + 2;

	// multiples of m, sign extended to the accumulator width
	logic [PART_W-1:0] m_one;
	logic [PART_W-1:0] m_two;

	assign m_one = {{2{multiplicand[EXT_W-1]}}, multiplicand};
	// 2m is a plain left shift, guard bits keep the sign
	assign m_two = {m_one[PART_W-2:0], 1'b0};

	// **************************************************
	// radix-4 recoding
	// **************************************************

	// digit is {b(2i+1), b(2i), b(2i-1)}
	always_comb begin
		case (digit)
			// runs of zeros or ones add nothing
			3'b000,
			3'b111: part = '0;
			// +m
			3'b001,
			3'b010: part = m_one;
			// +2m
			3'b011: part = m_two;
			// -2m, two's complement
			3'b100: part = ~m_two + 1'b1;
			// -m
			3'b101,
			3'b110: part = ~m_one + 1'b1;
			default: part = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- booth_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_cfg.svh"

module booth_multiplier (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      start,
	input  wire mul_pkg::mul_start_t operands,
	input  wire                      flush,
	output logic                     done,
	output mul_pkg::mul_prod_t       prod
);

	// datapath widths
	localparam int HALF   = `MUL_XLEN / 2;
	localparam int EXT_W  = `MUL_XLEN + 2;
	localparam int HI_W   = EXT_W + 2;
	// {hi accumulator, multiplier / low product, previous bit}
	localparam int P_W    = HI_W + EXT_W + 1;
	localparam int PROD_W = 2 * `MUL_XLEN;
	localparam int CNT_W  = $clog2(`MUL_STEPS + 1);

	// where the product sits once the steps are over
	localparam int FULL_LSB = EXT_W + 1 - 2 * `MUL_STEPS;
	localparam int WORD_LSB = EXT_W + 1 - 2 * `MUL_STEPS_W;
	localparam int WORD_PAD = PROD_W - (P_W - WORD_LSB);

	localparam logic [CNT_W-1:0] STEPS_FULL = CNT_W'(`MUL_STEPS);
	localparam logic [CNT_W-1:0] STEPS_WORD = CNT_W'(`MUL_STEPS_W);

	// control state
	logic [CNT_W-1:0] cnt_q;

	// datapath registers
	logic [P_W-1:0]   p_q;
	logic [EXT_W-1:0] mcand_q;
	logic             word_q;

	// combinational
	logic [EXT_W-1:0] mcand_ext;
	logic [EXT_W-1:0] mplier_ext;
	logic [HI_W-1:0]  part;
	logic [HI_W-1:0]  sum;
	logic [P_W-1:0]   p_next;
	logic [PROD_W-1:0] prod_full;
	logic [PROD_W-1:0] prod_word;

	// **************************************************
	// operand extension
	// **************************************************

	// sign or zero fill per flag
	// word mode fills from bit 31, giving the 34-bit value in 66 bits
	always_comb begin
		if (operands.word) begin
			mcand_ext  = {{(EXT_W - HALF){operands.signed_a & operands.multiplicand[HALF-1]}},
				operands.multiplicand[HALF-1:0]};
			mplier_ext = {{(EXT_W - HALF){operands.signed_b & operands.multiplier[HALF-1]}},
				operands.multiplier[HALF-1:0]};
		end else begin
			mcand_ext  = {{2{operands.signed_a & operands.multiplicand[`MUL_XLEN-1]}},
				operands.multiplicand};
			mplier_ext = {{2{operands.signed_b & operands.multiplier[`MUL_XLEN-1]}},
				operands.multiplier};
		end
	end

	// **************************************************
	// one radix-4 step
	// **************************************************

	// low three bits of p are always the current digit
	booth_encoder enc_i (
		.digit        (p_q[2:0]),
		.multiplicand (mcand_q),
		.part         (part)
	);

	// add into the upper field
	assign sum = p_q[P_W-1 -: HI_W] + part;

	// arithmetic shift right by two, sign from the new sum
	// low product bits move down into the multiplier field
	assign p_next = {{2{sum[HI_W-1]}}, sum, p_q[EXT_W:2]};

	// datapath, no reset needed
	always_ff @(posedge clk) begin
		if (start) begin
			// hi cleared, multiplier in the middle, bit -1 is zero
			p_q     <= {{HI_W{1'b0}}, mplier_ext, 1'b0};
			mcand_q <= mcand_ext;
			word_q  <= operands.word;
		end else if (cnt_q != '0) begin
			p_q <= p_next;
		end
	end

	// **************************************************
	// step counter and done
	// **************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_q <= '0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			// flush wins over a start in the same cycle
			if (flush) begin
				cnt_q <= '0;
			end else if (start) begin
				cnt_q <= operands.word ? STEPS_WORD : STEPS_FULL;
			end else if (cnt_q != '0) begin
				cnt_q <= cnt_q - 1'b1;
				// last step lands on this edge
				if (cnt_q == CNT_W'(1))
					done <= 1'b1;
			end
		end
	end

	// **************************************************
	// product alignment
	// **************************************************

	// 33 steps leave the product at bit 1
	assign prod_full = p_q[FULL_LSB +: PROD_W];

	// 17 steps leave it higher up, sign extend the 102 live bits
	assign prod_word = {{WORD_PAD{p_q[P_W-1]}}, p_q[P_W-1:WORD_LSB]};

	assign prod = word_q ? prod_word : prod_full;

endmodule

`default_nettype wire

//--- mul_issue.sv
`timescale 1ns/1ps
`default_nettype none

module mul_issue (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      req_valid,
	input  wire mul_pkg::mul_req_t   req,
	output logic                     req_ready,
	input  wire                      flush,
	input  wire                      done,
	output logic                     start,
	output mul_pkg::mul_start_t      operands,
	output mul_pkg::mul_sel_t        sel
);

	import mul_pkg::*;

	// one op in flight at most
	logic busy;
	logic accept;

	// decoded fields
	logic signed_a;
	logic signed_b;
	logic word;
	logic take_hi;

	assign req_ready = !busy;
	assign accept    = req_valid && req_ready;

	// **************************************************
	// op decode
	// **************************************************

	always_comb begin
		// mul and mulw only use low bits, signedness does not matter
		signed_a = 1'b1;
		signed_b = 1'b1;
		word     = 1'b0;
		take_hi  = 1'b0;
		case (req.op)
			OP_MULH: begin
				take_hi = 1'b1;
			end
			// rs1 signed, rs2 unsigned
			OP_MULHSU: begin
				signed_b = 1'b0;
				take_hi  = 1'b1;
			end
			OP_MULHU: begin
				signed_a = 1'b0;
				signed_b = 1'b0;
				take_hi  = 1'b1;
			end
			OP_MULW: begin
				word = 1'b1;
			end
			default: begin
				take_hi = 1'b0;
			end
		endcase
	end

	// **************************************************
	// busy state and start pulse
	// **************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			busy  <= 1'b0;
			start <= 1'b0;
		end else begin
			start <= accept;
			if (accept)
				busy <= 1'b1;
			// flush abandons, done finishes
			else if (flush || done)
				busy <= 1'b0;
		end
	end

	// operands and writeback select held from acceptance
	always_ff @(posedge clk) begin
		if (accept) begin
			operands.signed_a     <= signed_a;
			operands.signed_b     <= signed_b;
			operands.word         <= word;
			operands.multiplicand <= req.src_a;
			operands.multiplier   <= req.src_b;
			sel.take_hi           <= take_hi;
			sel.word              <= word;
		end
	end

endmodule

`default_nettype wire

//--- mul_writeback.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_cfg.svh"

module mul_writeback (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      done,
	input  wire mul_pkg::mul_prod_t  prod,
	input  wire mul_pkg::mul_sel_t   sel,
	output logic                     resp_valid,
	output logic [`MUL_XLEN-1:0]     resp_data
);

	localparam int HALF = `MUL_XLEN / 2;

	// half picked for mulh*
	logic [`MUL_XLEN-1:0] half;
	// value as written to rd
	logic [`MUL_XLEN-1:0] result;

	// **************************************************
	// result select
	// **************************************************

	always_comb begin
		half = sel.take_hi ? prod.hi : prod.lo;
		// mulw keeps 32 bits, sign extended from bit 31
		if (sel.word)
			result = {{HALF{prod.lo[HALF-1]}}, prod.lo[HALF-1:0]};
		else
			result = half;
	end

	// **************************************************
	// response register
	// **************************************************

	// one-cycle pulse, done is itself a single cycle
	always_ff @(posedge clk) begin
		if (rst)
			resp_valid <= 1'b0;
		else
			resp_valid <= done;
	end

	// data only moves on done, no reset
	always_ff @(posedge clk) begin
		if (done)
			resp_data <= result;
	end

endmodule

`default_nettype wire

//--- mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_cfg.svh"

module mul_unit (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      req_valid,
	input  wire mul_pkg::mul_req_t   req,
	output logic                     req_ready,
	input  wire                      flush,
	output logic                     resp_valid,
	output logic [`MUL_XLEN-1:0]     resp_data
);

	import mul_pkg::*;

	// issue to multiplier
	logic       start;
	mul_start_t operands;

	// multiplier to writeback
	logic       done;
	mul_prod_t  prod;

	// issue to writeback
	mul_sel_t   sel;

	// **************************************************
	// request side
	// **************************************************

	mul_issue issue_i (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready),
		.flush     (flush),
		.done      (done),
		.start     (start),
		.operands  (operands),
		.sel       (sel)
	);

	// iterative booth core
	booth_multiplier mult_i (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.operands (operands),
		.flush    (flush),
		.done     (done),
		.prod     (prod)
	);

	// result side, no flush here
	mul_writeback wb_i (
		.clk        (clk),
		.rst        (rst),
		.done       (done),
		.prod       (prod),
		.sel        (sel),
		.resp_valid (resp_valid),
		.resp_data  (resp_data)
	);

endmodule

`default_nettype wire

//--- mul_unit_assert.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit_assert (
	input wire clk,
	input wire rst,
	input wire req_valid,
	input wire req_ready,
	input wire flush,
	input wire done,
	input wire resp_valid
);

	// number of failed assertions so far
	int fails = 0;

	// **************************************************
	// result pulse
	// **************************************************

	// never back to back
	resp_single: assert property (@(posedge clk) disable iff (rst)
		resp_valid |=> !resp_valid)
		else begin
			$error("resp_valid high for two cycles in a row");
			fails++;
		end

	// **************************************************
	// request handshake
	// **************************************************

	// ready drops right after acceptance
	ready_falls: assert property (@(posedge clk) disable iff (rst)
		(req_valid && req_ready) |=> !req_ready)
		else begin
			$error("req_ready still high after acceptance");
			fails++;
		end

	// and comes back only with the result or after a flush
	ready_rises: assert property (@(posedge clk) disable iff (rst)
		$rose(req_ready) |-> (resp_valid || $past(flush)))
		else begin
			$error("req_ready rose without resp_valid or flush");
			fails++;
		end

	// flush of a busy unit before done kills the pending result pulse
	flush_quiet: assert property (@(posedge clk) disable iff (rst)
		$past(flush && !req_ready && !done) |=> !resp_valid)
		else begin
			$error("resp_valid after a flush of a busy unit");
			fails++;
		end

endmodule

// checker rides along inside the top level
bind mul_unit mul_unit_assert assert_i (
	.clk        (clk),
	.rst        (rst),
	.req_valid  (req_valid),
	.req_ready  (req_ready),
	.flush      (flush),
	.done       (done),
	.resp_valid (resp_valid)
);

`default_nettype wire

//--- tb_mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_cfg.svh"

module tb_mul_unit;

	import mul_pkg::*;

	// latencies from acceptance edge to resp_valid
	localparam int LAT_FULL  = 35;
	localparam int LAT_WORD  = 19;
	localparam int NUM_RAND  = 200;
	localparam int NUM_HOLD  = 20;
	localparam int NUM_FLUSH = 20;
	// corners run 6 x 6 operand pairs per op and a flush test costs two ops
	localparam int NUM_OPS   = NUM_RAND + 180 + NUM_HOLD + 2 * NUM_FLUSH;
	localparam int WATCHDOG  = NUM_OPS * 40 + 100;

	logic                 clk;
	logic                 rst;
	logic                 req_valid;
	mul_req_t             req;
	logic                 req_ready;
	logic                 flush;
	logic                 resp_valid;
	logic [`MUL_XLEN-1:0] resp_data;

	// model state for the one op in flight
	logic                 pending;
	logic [`MUL_XLEN-1:0] exp_data;
	mul_op_e              exp_op;
	int                   exp_lat;
	int                   acc_cyc;
	int                   cyc;
	int                   results;
	int                   expected;
	logic [31:0]          rng;

	mul_op_e              ops [5] = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_MULW};
	logic [`MUL_XLEN-1:0] corners [6] = '{64'd0, 64'd1, {64{1'b1}}, 64'h8000_0000_0000_0000,
		64'h0000_0000_8000_0000, 64'h7fff_ffff_ffff_ffff};

	mul_unit mul_unit_i (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (req_valid),
		.req        (req),
		.req_ready  (req_ready),
		.flush      (flush),
		.resp_valid (resp_valid),
		.resp_data  (resp_data)
	);

	// **************************************************
	// helpers
	// **************************************************

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng = x;
		return x;
	endfunction

	// behavioral product at 128 bits from operands extended per op
	function automatic logic [`MUL_XLEN-1:0] model_result(input mul_op_e op,
			input logic [`MUL_XLEN-1:0] a, input logic [`MUL_XLEN-1:0] b);
		logic [127:0] ea;
		logic [127:0] eb;
		logic [127:0] p;
		logic [31:0]  w;
		ea = (op == OP_MULH || op == OP_MULHSU) ? {{64{a[63]}}, a} : {64'd0, a};
		eb = (op == OP_MULH) ? {{64{b[63]}}, b} : {64'd0, b};
		p  = ea * eb;
		// word result is the low 32 bits sign extended
		w  = a[31:0] * b[31:0];
		case (op)
			OP_MULW: return {{32{w[31]}}, w};
			OP_MUL:  return p[63:0];
			default: return p[127:64];
		endcase
	endfunction

	task automatic report_failure(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		$display("sim failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_data(input logic [`MUL_XLEN-1:0] got,
			input logic [`MUL_XLEN-1:0] exp, input mul_op_e op);
		if (got !== exp)
			report_failure($sformatf("%s result %h, expected %h", op.name(), got, exp));
	endtask

	task automatic check_cycles(input int got, input int exp);
		if (got != exp)
			report_failure($sformatf("latency %0d cycles, expected %0d", got, exp));
	endtask

	// one request with hold cycles of junk on req while busy
	// flush_at >= 0 abandons it
	task automatic run_op(input mul_op_e op, input logic [`MUL_XLEN-1:0] a,
			input logic [`MUL_XLEN-1:0] b, input int hold, input int flush_at);
		int lat;
		lat = (op == OP_MULW) ? LAT_WORD : LAT_FULL;
		@(posedge clk);
		#1;
		req_valid = 1'b1;
		req.op    = op;
		req.src_a = a;
		req.src_b = b;
		// sample the ready level mid cycle
		@(negedge clk);
		while (!req_ready)
			@(negedge clk);
		acc_cyc = cyc + 1;
		@(posedge clk);
		#1;
		exp_data = model_result(op, a, b);
		exp_op   = op;
		exp_lat  = lat;
		pending  = (flush_at < 0);
		if (flush_at < 0)
			expected++;
		// other requests while busy must be ignored
		for (int i = 0; i < hold; i++) begin
			req.op    = ops[xorshift32() % 5];
			req.src_a = {xorshift32(), xorshift32()};
			req.src_b = {xorshift32(), xorshift32()};
			@(posedge clk);
			#1;
		end
		req_valid = 1'b0;
		if (flush_at >= 0) begin
			// any cycle before done
			flush_at = flush_at % (lat - 1);
			repeat (flush_at)
				@(posedge clk);
			#1;
			flush = 1'b1;
			@(posedge clk);
			#1;
			flush = 1'b0;
			@(negedge clk);
			if (!req_ready)
				report_failure("req_ready not high in the cycle after a flush");
		end else begin
			wait (pending == 1'b0);
		end
	endtask

	// **************************************************
	// clock, cycle count, response monitor
	// **************************************************

	initial begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	always @(negedge clk) begin
		if (mul_unit_i.assert_i.fails != 0)
			report_failure("a bound assertion on mul_unit failed");
		if (!rst && resp_valid) begin
			if (!pending) begin
				report_failure("resp_valid with no operation outstanding");
			end else begin
				check_data(resp_data, exp_data, exp_op);
				check_cycles(cyc - acc_cyc, exp_lat);
				if (!req_ready)
					report_failure("req_ready did not return with resp_valid");
				results++;
				pending = 1'b0;
			end
		end
	end

	initial begin
		repeat (WATCHDOG)
			@(posedge clk);
		report_failure("watchdog expired before all operations finished");
	end

	// **************************************************
	// test sequence
	// **************************************************

	initial begin
		rst       = 1'b1;
		req_valid = 1'b0;
		req       = '0;
		flush     = 1'b0;
		pending   = 1'b0;
		cyc       = 0;
		results   = 0;
		expected  = 0;
		rng       = 32'h2298639b;
		repeat (5)
			@(posedge clk);
		#1;
		rst = 1'b0;
		// idle after reset while the monitor catches any stray pulse
		@(negedge clk);
		if (req_ready !== 1'b1 || resp_valid !== 1'b0)
			report_failure("unit not idle after reset");
		repeat (5)
			@(posedge clk);
		for (int n = 0; n < NUM_RAND; n++)
			run_op(ops[xorshift32() % 5], {xorshift32(), xorshift32()},
				{xorshift32(), xorshift32()}, 0, -1);
		for (int i = 0; i < 6; i++)
			for (int j = 0; j < 6; j++)
				for (int k = 0; k < 5; k++)
					run_op(ops[k], corners[i], corners[j], 0, -1);
		for (int n = 0; n < NUM_HOLD; n++)
			run_op(ops[xorshift32() % 5], {xorshift32(), xorshift32()},
				{xorshift32(), xorshift32()}, 1 + int'(xorshift32() % 15), -1);
		// flushed op followed right away by a clean one
		for (int n = 0; n < NUM_FLUSH; n++) begin
			run_op(ops[xorshift32() % 5], {xorshift32(), xorshift32()},
				{xorshift32(), xorshift32()}, 0, int'(xorshift32() % 64));
			run_op(ops[xorshift32() % 5], {xorshift32(), xorshift32()},
				{xorshift32(), xorshift32()}, 0, -1);
		end
		repeat (40)
			@(posedge clk);
		if (results != expected) begin
			report_failure($sformatf("%0d results seen, %0d expected", results, expected));
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
mul_pkg.sv
booth_encoder.sv
booth_multiplier.sv
mul_issue.sv
mul_writeback.sv
mul_unit.sv
mul_unit_assert.sv
tb_mul_unit.sv
